//--- Makefile
VERILATOR ?= verilator
TOP ?= connectCountTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timing -j 0
PASS_TEXT ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
+incdir+testbench
rtl/graphPkg.sv
rtl/apbRegPkg.sv
rtl/slotFifo.sv
rtl/componentCounter.sv
rtl/slotMemory.sv
rtl/maskRegs.sv
rtl/connectCountCore.sv
testbench/connectCountTb.sv

//--- rtl/apbRegPkg.sv
package apbRegPkg;

    localparam int apbAddrBits = 4;
    localparam int apbDataBits = 32;

    // Register offsets
    localparam logic [apbAddrBits-1:0] regMaskLo = 4'h0;
    localparam logic [apbAddrBits-1:0] regMaskHi = 4'h4;
    localparam logic [apbAddrBits-1:0] regStatus = 4'h8;

    // Status layout, level in the low bits
    localparam int statusLevelBits = 7;
    // Sticky overflow, write 1 to clear
    localparam int statusOverflowBit = 8;

endpackage

//--- rtl/componentCounter.sv
`timescale 1ns/1ns

module componentCounter import graphPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  adjWord_t               mask,
    input  adjWord_t               graphIn,
    input  logic [slotBits-1:0]    slotIn,
    input  logic                   startValid,
    input  logic [fifoDepthBits:0] fifoLevel,
    output logic                   fifoRead,
    output logic                   doneValid,
    output logic [countBits-1:0]   resultCount,
    output logic [slotBits-1:0]    slotOut
);

    adjWord_t masked;
    logic [vertexCount-1:0][vertexCount-1:0] symRows;
    logic [vertexCount-1:0][vertexCount-1:0] adj;
    logic [vertexCount-1:0] reach;
    logic [vertexCount-1:0] visited;
    logic [vertexCount-1:0] neighbours;
    logic [vertexCount-1:0] grown;
    logic [vertexCount-1:0] nextVisited;
    logic [vertexCount-1:0] seed;
    logic [countBits-1:0] count;
    logic waiting;
    logic growing;

    // Undirected edges from either direction, no self loops
    always_comb begin
        masked.flat = graphIn.flat & mask.flat;
        for (int u = 0; u < vertexCount; u++) begin
            for (int v = 0; v < vertexCount; v++) begin
                symRows[u][v] = (u != v) && (masked.rows[u][v] || masked.rows[v][u]);
            end
        end
    end

    always_comb begin
        neighbours = '0;
        for (int i = 0; i < vertexCount; i++) begin
            if (reach[i]) begin
                neighbours = neighbours | adj[i];
            end
        end
    end

    assign grown = reach | neighbours;
    assign nextVisited = visited | reach;

    // Lowest vertex not yet in any component
    always_comb begin
        seed = '0;
        for (int i = vertexCount - 1; i >= 0; i--) begin
            if (!nextVisited[i]) begin
                seed = '0;
                seed[i] = 1'b1;
            end
        end
    end

    // One graph in flight at a time
    assign fifoRead = !waiting && !growing && (fifoLevel != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            waiting <= 1'b0;
            growing <= 1'b0;
            doneValid <= 1'b0;
            reach <= '0;
            visited <= '0;
            count <= '0;
        end else begin
            doneValid <= 1'b0;
            if (fifoRead) begin
                waiting <= 1'b1;
            end
            if (waiting && startValid) begin
                waiting <= 1'b0;
                growing <= 1'b1;
                reach <= vertexCount'(1);
                visited <= '0;
                count <= '0;
            end
            if (growing) begin
                if (grown != reach) begin
                    reach <= grown;
                end else begin
                    // Reach set closed, one more component
                    count <= count + 1'b1;
                    visited <= nextVisited;
                    if (&nextVisited) begin
                        growing <= 1'b0;
                        doneValid <= 1'b1;
                    end else begin
                        reach <= seed;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (waiting && startValid) begin
            adj <= symRows;
            slotOut <= slotIn;
        end
    end

    assign resultCount = count;

    startOnlyWhenWaiting: assert property (@(posedge clk) disable iff (!arstN)
        startValid |-> waiting);

    countInRange: assert property (@(posedge clk) disable iff (!arstN)
        doneValid |-> (resultCount >= 1) && (resultCount <= countBits'(vertexCount)));

endmodule

//--- rtl/connectCountCore.sv
`timescale 1ns/1ns

module connectCountCore import graphPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,

    input  logic                 inValid,
    input  logic [adjBits-1:0]   graphIn,
    input  logic [extraBits-1:0] extraIn,

    output logic                 outValid,
    output logic [countBits-1:0] connectCount,
    output logic [extraBits-1:0] extraOut,

    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [3:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr
);

    logic [slotBits-1:0] slotIdx;
    logic wrapped;
    logic primed;

    logic fifoRead;
    logic [fifoWidth-1:0] fifoData;
    logic fifoDataValid;
    logic [fifoDepthBits:0] fifoLevel;
    logic fifoOverflow;
    adjWord_t fifoGraph;
    logic [slotBits-1:0] fifoSlot;

    adjWord_t mask;
    logic doneValid;
    logic [countBits-1:0] doneCount;
    logic [slotBits-1:0] doneSlot;
    logic tagValid;

    // Tag memory holds garbage until the first full ring turn has been written
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            slotIdx <= '0;
            wrapped <= 1'b0;
            primed <= 1'b0;
        end else begin
            slotIdx <= slotIdx + 1'b1;
            if (slotIdx == slotBits'(slotCount - 1)) begin
                wrapped <= 1'b1;
            end
            primed <= wrapped;
        end
    end

    slotFifo inputFifo (
        .clk(clk),
        .arstN(arstN),
        .writeEnable(inValid),
        .dataIn({graphIn, slotIdx}),
        .readRequest(fifoRead),
        .dataOut(fifoData),
        .dataOutValid(fifoDataValid),
        .level(fifoLevel),
        .overflow(fifoOverflow)
    );

    assign fifoGraph.flat = fifoData[fifoWidth-1:slotBits];
    assign fifoSlot = fifoData[slotBits-1:0];

    componentCounter counter (
        .clk(clk),
        .arstN(arstN),
        .mask(mask),
        .graphIn(fifoGraph),
        .slotIn(fifoSlot),
        .startValid(fifoDataValid),
        .fifoLevel(fifoLevel),
        .fifoRead(fifoRead),
        .doneValid(doneValid),
        .resultCount(doneCount),
        .slotOut(doneSlot)
    );

    slotMemory #(.width(countBits)) resultMemory (
        .clk(clk),
        .writeEnable(doneValid),
        .writeAddr(doneSlot),
        .dataIn(doneCount),
        .readAddr(slotIdx),
        .dataOut(connectCount)
    );

    // Every cycle gets a tag, empty ones included
    slotMemory #(.width(1 + extraBits)) tagMemory (
        .clk(clk),
        .writeEnable(1'b1),
        .writeAddr(slotIdx),
        .dataIn({inValid, extraIn}),
        .readAddr(slotIdx),
        .dataOut({tagValid, extraOut})
    );

    assign outValid = tagValid && primed;

    maskRegs regs (
        .clk(clk),
        .arstN(arstN),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .fifoLevel(fifoLevel),
        .overflowPulse(fifoOverflow),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .mask(mask)
    );

endmodule

//--- rtl/graphPkg.sv
package graphPkg;

    // Graph shape
    localparam int vertexCount = 8;
    localparam int adjBits = vertexCount * vertexCount;

    // Time slot ring
    localparam int slotBits = 6;
    localparam int slotCount = 1 << slotBits;

    localparam int countBits = 4;
    localparam int extraBits = 2;

    // Input FIFO carries the graph and its slot
    localparam int fifoDepthBits = 6;
    localparam int fifoDepth = 1 << fifoDepthBits;
    localparam int fifoWidth = adjBits + slotBits;

    // Row u bit v marks an edge from u to v
    typedef union packed {
        logic [adjBits-1:0] flat;
        logic [vertexCount-1:0][vertexCount-1:0] rows;
    } adjWord_t;

endpackage

//--- rtl/maskRegs.sv
`timescale 1ns/1ns

module maskRegs import graphPkg::*, apbRegPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [apbAddrBits-1:0] paddr,
    input  logic [apbDataBits-1:0] pwdata,
    input  logic [fifoDepthBits:0] fifoLevel,
    input  logic                   overflowPulse,
    output logic [apbDataBits-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output adjWord_t               mask
);

    logic access;
    logic mapped;
    logic overflowFlag;
    logic [apbDataBits-1:0] statusWord;

    assign access = psel && penable;
    assign mapped = (paddr == regMaskLo) || (paddr == regMaskHi) || (paddr == regStatus);
    assign pready = 1'b1;
    assign pslverr = access && !mapped;

    always_comb begin
        statusWord = '0;
        statusWord[statusLevelBits-1:0] = fifoLevel;
        statusWord[statusOverflowBit] = overflowFlag;
    end

    always_comb begin
        case (paddr)
            regMaskLo: prdata = mask.flat[apbDataBits-1:0];
            regMaskHi: prdata = mask.flat[adjBits-1:apbDataBits];
            regStatus: prdata = statusWord;
            default:   prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mask.flat <= '0;
            overflowFlag <= 1'b0;
        end else begin
            if (access && pwrite && paddr == regMaskLo) begin
                mask.flat[apbDataBits-1:0] <= pwdata;
            end
            if (access && pwrite && paddr == regMaskHi) begin
                mask.flat[adjBits-1:apbDataBits] <= pwdata;
            end
            // A new overflow wins over a clear in the same cycle
            if (overflowPulse) begin
                overflowFlag <= 1'b1;
            end else if (access && pwrite && paddr == regStatus && pwdata[statusOverflowBit]) begin
                overflowFlag <= 1'b0;
            end
        end
    end

    penableNeedsPsel: assert property (@(posedge clk) disable iff (!arstN)
        penable |-> psel);

endmodule

//--- rtl/slotFifo.sv
`timescale 1ns/1ns

module slotFifo import graphPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   writeEnable,
    input  logic [fifoWidth-1:0]   dataIn,
    input  logic                   readRequest,
    output logic [fifoWidth-1:0]   dataOut,
    output logic                   dataOutValid,
    output logic [fifoDepthBits:0] level,
    output logic                   overflow
);

    logic [fifoWidth-1:0] mem [fifoDepth];
    logic [fifoDepthBits-1:0] wrPtr;
    logic [fifoDepthBits-1:0] rdPtr;
    logic full;
    logic accept;

    assign full = (level == (fifoDepthBits + 1)'(fifoDepth));
    // Writes into a full buffer are lost
    assign accept = writeEnable && !full;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
            dataOutValid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (accept) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (readRequest) begin
                rdPtr <= rdPtr + 1'b1;
            end
            level <= level + (fifoDepthBits + 1)'(accept) - (fifoDepthBits + 1)'(readRequest);
            dataOutValid <= readRequest;
            overflow <= writeEnable && full;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wrPtr] <= dataIn;
        end
        if (readRequest) begin
            dataOut <= mem[rdPtr];
        end
    end

    // Reader is responsible for checking the level
    noReadWhenEmpty: assert property (@(posedge clk) disable iff (!arstN)
        readRequest |-> level != '0);

    levelInRange: assert property (@(posedge clk) disable iff (!arstN)
        level <= (fifoDepthBits + 1)'(fifoDepth));

endmodule

//--- rtl/slotMemory.sv
`timescale 1ns/1ns

module slotMemory import graphPkg::*; #(
    parameter int width = 1
) (
    input  logic                clk,
    input  logic                writeEnable,
    input  logic [slotBits-1:0] writeAddr,
    input  logic [width-1:0]    dataIn,
    input  logic [slotBits-1:0] readAddr,
    output logic [width-1:0]    dataOut
);

    logic [width-1:0] mem [slotCount];

    // Same-address read sees the value from before the write
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= dataIn;
        end
        dataOut <= mem[readAddr];
    end

endmodule

//--- testbench/graphModel.svh
`ifndef GRAPH_MODEL_SVH
`define GRAPH_MODEL_SVH

// Expected output of one sampled input cycle
typedef struct packed {
    logic valid;
    logic countKnown;
    logic [extraBits-1:0] extra;
    logic [countBits-1:0] count;
} slotEntry_t;

typedef slotEntry_t entryQueue_t[$];

// Label merging over every edge seen in either direction
function automatic logic [countBits-1:0] modelCount(adjWord_t graph, adjWord_t mask);
    adjWord_t edges;
    int label [vertexCount];
    int oldLabel;
    int newLabel;
    int components;
    edges.flat = graph.flat & mask.flat;
    for (int i = 0; i < vertexCount; i++) begin
        label[i] = i;
    end
    for (int u = 0; u < vertexCount; u++) begin
        for (int v = 0; v < vertexCount; v++) begin
            if (u != v && edges.rows[u][v]) begin
                oldLabel = label[v];
                newLabel = label[u];
                for (int k = 0; k < vertexCount; k++) begin
                    if (label[k] == oldLabel) begin
                        label[k] = newLabel;
                    end
                end
            end
        end
    end
    // One representative per group still carries its own index
    components = 0;
    for (int i = 0; i < vertexCount; i++) begin
        if (label[i] == i) begin
            components++;
        end
    end
    return countBits'(components);
endfunction

`endif

//--- testbench/connectCountTb.sv
`timescale 1ns/1ns

module connectCountTb import graphPkg::*, apbRegPkg::*; ();

    logic clk;
    logic arstN;
    logic inValid;
    logic [adjBits-1:0] graphIn;
    logic [extraBits-1:0] extraIn;
    logic outValid;
    logic [countBits-1:0] connectCount;
    logic [extraBits-1:0] extraOut;
    logic psel;
    logic penable;
    logic pwrite;
    logic [apbAddrBits-1:0] paddr;
    logic [apbDataBits-1:0] pwdata;
    logic [apbDataBits-1:0] prdata;
    logic pready;
    logic pslverr;

    `include "graphModel.svh"

    adjWord_t tbMask;
    logic countTracked;
    entryQueue_t history;
    slotEntry_t expected = '0;
    logic checkActive = 1'b0;

    connectCountCore uut (
        .clk(clk),
        .arstN(arstN),
        .inValid(inValid),
        .graphIn(graphIn),
        .extraIn(extraIn),
        .outValid(outValid),
        .connectCount(connectCount),
        .extraOut(extraOut),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopWithError(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    // Every sampled cycle goes in, the entry from one ring turn ago comes out
    always @(posedge clk) begin
        slotEntry_t entry;
        if (arstN) begin
            entry.valid = inValid;
            entry.countKnown = countTracked;
            entry.extra = extraIn;
            entry.count = modelCount(adjWord_t'(graphIn), tbMask);
            history.push_back(entry);
            if (history.size() == slotCount + 1) begin
                expected <= history.pop_front();
                checkActive <= 1'b1;
            end
        end
    end

    quietUntilPrimed: assert property (@(posedge clk) !checkActive |-> !outValid)
        else stopWithError($sformatf("error at %0t ns: outValid set before any item", $time));

    validCheck: assert property (@(posedge clk) checkActive |-> outValid == expected.valid)
        else stopWithError($sformatf("error at %0t ns: outValid %0b, expected %0b",
                                     $time, $sampled(outValid), $sampled(expected.valid)));

    extraCheck: assert property (@(posedge clk)
        checkActive && expected.valid |-> extraOut == expected.extra)
        else stopWithError($sformatf("error at %0t ns: extraOut %0d, expected %0d",
                                     $time, $sampled(extraOut), $sampled(expected.extra)));

    countCheck: assert property (@(posedge clk)
        checkActive && expected.valid && expected.countKnown |-> connectCount == expected.count)
        else stopWithError($sformatf("error at %0t ns: connectCount %0d, expected %0d",
                                     $time, $sampled(connectCount), $sampled(expected.count)));

    task automatic apbAccess(input logic write, input logic [apbAddrBits-1:0] addr,
                             input logic [apbDataBits-1:0] wdata,
                             output logic [apbDataBits-1:0] rdata, output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;
        err = pslverr;
        assert (pready) else stopWithError($sformatf("error at %0t ns: pready low", $time));
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic writeReg(input logic [apbAddrBits-1:0] addr, input logic [apbDataBits-1:0] data);
        logic [apbDataBits-1:0] rdata;
        logic err;
        apbAccess(1'b1, addr, data, rdata, err);
        assert (!err) else stopWithError($sformatf("error at %0t ns: pslverr on write to 0x%0h",
                                                   $time, addr));
    endtask

    task automatic readCheck(input logic [apbAddrBits-1:0] addr, input logic [apbDataBits-1:0] want,
                             input logic [apbDataBits-1:0] care);
        logic [apbDataBits-1:0] rdata;
        logic err;
        apbAccess(1'b0, addr, '0, rdata, err);
        assert (!err && (rdata & care) == (want & care))
            else stopWithError($sformatf("error at %0t ns: read 0x%0h gave 0x%08h, expected 0x%08h",
                                         $time, addr, rdata, want & care));
    endtask

    task automatic driveCycle(input logic valid, input adjWord_t graph,
                              input logic [extraBits-1:0] extra);
        @(negedge clk);
        inValid = valid;
        graphIn = graph.flat;
        extraIn = extra;
    endtask

    // One item, then an idle stretch of 20 to 40 cycles in total
    task automatic sendSpaced(input adjWord_t graph, input logic [extraBits-1:0] extra);
        int gap;
        gap = int'($urandom_range(40, 20));
        driveCycle(1'b1, graph, extra);
        repeat (gap - 1) driveCycle(1'b0, '0, '0);
    endtask

    function automatic adjWord_t randomGraph(input int sparsity);
        adjWord_t graph;
        graph.flat = '1;
        repeat (sparsity) graph.flat = graph.flat & {$urandom(), $urandom()};
        return graph;
    endfunction

    function automatic int pendingItems();
        int pending;
        pending = int'(expected.valid);
        foreach (history[i]) begin
            pending += int'(history[i].valid);
        end
        return pending;
    endfunction

    task automatic waitDrained(input int limit);
        int waited;
        waited = 0;
        while (pendingItems() != 0) begin
            if (waited >= limit) begin
                stopWithError("timeout: items still waiting to leave the slot ring");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    task automatic waitFifoEmpty(input int limit);
        logic [apbDataBits-1:0] rdata;
        logic err;
        int reads;
        reads = 0;
        rdata = '1;
        while (rdata[statusLevelBits-1:0] != '0) begin
            if (reads >= limit) begin
                stopWithError("timeout: FIFO level never dropped back to zero");
            end else begin
                reads++;
                apbAccess(1'b0, regStatus, '0, rdata, err);
            end
        end
    endtask

    initial begin
        adjWord_t graph;
        logic [apbDataBits-1:0] rdata;
        logic [apbDataBits-1:0] overflowMask;
        logic err;
        arstN = 1'b0;
        inValid = 1'b0;
        graphIn = '0;
        extraIn = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        tbMask.flat = '0;
        countTracked = 1'b1;
        overflowMask = apbDataBits'(1) << statusOverflowBit;
        void'($urandom(32'h4705_f905));
        repeat (10) @(negedge clk);
        arstN = 1'b1;

        readCheck(regStatus, '0, '1);
        readCheck(regMaskLo, '0, '1);
        readCheck(regMaskHi, '0, '1);

        writeReg(regMaskLo, '1);
        writeReg(regMaskHi, '1);
        tbMask.flat = '1;
        graph.flat = '0;
        assert (modelCount(graph, tbMask) == 4'd8) else stopWithError("model: empty graph not 8");
        sendSpaced(graph, 2'd1);
        graph.flat = '1;
        assert (modelCount(graph, tbMask) == 4'd1) else stopWithError("model: full graph not 1");
        sendSpaced(graph, 2'd2);
        graph.flat = '0;
        for (int i = 0; i < vertexCount - 1; i++) begin
            graph.rows[i][i + 1] = 1'b1;
        end
        assert (modelCount(graph, tbMask) == 4'd1) else stopWithError("model: path graph not 1");
        sendSpaced(graph, 2'd3);
        repeat (40) sendSpaced(randomGraph(2 + int'($urandom_range(2))),
                               extraBits'($urandom_range(3)));
        waitDrained(200);

        // Only rows 0 to 3 survive the mask
        writeReg(regMaskLo, '1);
        writeReg(regMaskHi, '0);
        tbMask.flat = {32'h0, 32'hffff_ffff};
        readCheck(regMaskLo, 32'hffff_ffff, '1);
        readCheck(regMaskHi, '0, '1);
        graph.flat = {32'hffff_ffff, 32'h0};
        assert (modelCount(graph, tbMask) == 4'd8) else stopWithError("model: high half not 8");
        sendSpaced(graph, 2'd0);
        repeat (15) sendSpaced(randomGraph(1 + int'($urandom_range(2))),
                               extraBits'($urandom_range(3)));
        waitDrained(200);

        // Back to back until the FIFO overflows
        countTracked = 1'b0;
        repeat (100) driveCycle(1'b1, randomGraph(2), extraBits'($urandom_range(3)));
        driveCycle(1'b0, '0, '0);
        countTracked = 1'b1;
        readCheck(regStatus, overflowMask, overflowMask);
        writeReg(regStatus, overflowMask);
        readCheck(regStatus, '0, overflowMask);
        apbAccess(1'b0, 4'hc, '0, rdata, err);
        assert (err) else stopWithError("no pslverr on a read of offset 0xC");
        apbAccess(1'b1, 4'hc, '0, rdata, err);
        assert (err) else stopWithError("no pslverr on a write to offset 0xC");
        waitFifoEmpty(400);
        waitDrained(200);
        readCheck(regStatus, '0, '1);

        $display("=== PASS ===");
        $finish;
    end

endmodule
